/* source/zx_pkg.sv */
/*
 Shared types, enums and memory-map constants for the 128K memory and port unit
*/
package zx_pkg;

	// ==================================================
	// Bus and store widths
	// ==================================================
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  data_t;
	typedef logic [2:0]  bank_t;
	typedef logic [1:0]  rom_page_t;

	// RAM banks low, ROM pages from 128K upward
	typedef logic [17:0] phys_addr_t;

	// ==================================================
	// Enums
	// ==================================================
	typedef enum logic [1:0] {
		model_128   = 2'd0,
		model_48    = 2'd1,
		model_plus3 = 2'd2
	} model_t;

	// Host handshake sequencer
	typedef enum logic [1:0] {
		st_idle,
		st_access,
		st_ack,
		st_release
	} bus_state_t;

	// ==================================================
	// Memory map
	// ==================================================
	localparam int PAGE_OFFSET_W = 14;
	localparam int RAM_BANKS     = 8;
	localparam int ROM_PAGES     = 4;
	localparam int STORE_DEPTH   = (RAM_BANKS + ROM_PAGES) << PAGE_OFFSET_W;

	localparam phys_addr_t ROM_BASE = phys_addr_t'(RAM_BANKS << PAGE_OFFSET_W);

	// Fixed banks behind 4000 and 8000
	localparam bank_t BANK_WIN1 = 3'd5;
	localparam bank_t BANK_WIN2 = 3'd2;

	// Paging register bits
	localparam int PAGE_LOCK_BIT  = 5;
	localparam int ROM_SEL_BIT    = 4;
	localparam int SCR_BIT        = 3;
	localparam int P3_SPECIAL_BIT = 0;

	localparam data_t IO_IDLE_DATA = 8'hFF;

endpackage

/* source/bus_ctrl.sv */
/*
 Host bus sequencer: runs the four-phase req/ack handshake, issues one
 access strobe per request and latches the read data for the host
*/
`timescale 1ns/1ps

module bus_ctrl (
	input  logic          clk_sys,
	input  logic          reset,
	input  logic          bus_req,
	input  logic          bus_io,
	input  logic          bus_wr,
	input  zx_pkg::data_t io_rdata,
	input  zx_pkg::data_t mem_rdata,
	output logic          bus_ack,
	output zx_pkg::data_t bus_rdata,
	output logic          acc_stb
);
	import zx_pkg::*;

	bus_state_t state;
	bus_state_t state_next;
	logic       ack_set;
	logic       ack_clr;
	logic       capture;
	data_t      rdata_sel;

	// ==================================================
	// Next state
	// ==================================================
	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (bus_req) begin
					state_next = st_access;
				end
			end
			st_access: begin
				state_next = st_ack;
			end
			// Hold here as long as the host keeps bus_req high
			st_ack: begin
				if (bus_ack && !bus_req) begin
					state_next = st_release;
				end
			end
			st_release: begin
				state_next = st_idle;
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	// One access per request
	assign acc_stb = (state == st_access);

	// First cycle of st_ack, store data is registered by now
	assign capture = (state == st_ack) && !bus_ack;
	assign ack_set = capture;
	assign ack_clr = (state == st_release);

	// Read data source follows the access type
	assign rdata_sel = bus_io ? io_rdata : mem_rdata;

	// ==================================================
	// State and handshake registers
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= st_idle;
			bus_ack <= 1'b0;
		end else begin
			state <= state_next;
			if (ack_set) begin
				bus_ack <= 1'b1;
			end else if (ack_clr) begin
				bus_ack <= 1'b0;
			end
		end
	end

	// Read data, held until the next read completes
	always_ff @(posedge clk_sys) begin
		if (capture && !bus_wr) begin
			bus_rdata <= rdata_sel;
		end
	end

endmodule

/* source/io_ports.sv */
/*
 I/O port decoding: 7FFD and 1FFD paging registers, the ULA port at FE
 and the model latch
*/
`timescale 1ns/1ps

module io_ports (
	input  logic              clk_sys,
	input  logic              reset,
	input  zx_pkg::model_t    model,
	input  logic              acc_stb,
	input  logic              bus_io,
	input  logic              bus_wr,
	input  zx_pkg::cpu_addr_t bus_addr,
	input  zx_pkg::data_t     bus_wdata,
	input  logic              ear_in,
	output zx_pkg::data_t     io_rdata,
	output zx_pkg::data_t     page_reg,
	output zx_pkg::data_t     page_reg_p3,
	output zx_pkg::model_t    model_q,
	output logic [2:0]        border,
	output logic              ear_out,
	output logic              mic_out
);
	import zx_pkg::*;

	logic  io_wr_stb;
	logic  is_plus3;
	logic  page_disable;
	logic  sel_7ffd;
	logic  sel_1ffd;
	logic  sel_ula;
	data_t ula_rdata;

	assign io_wr_stb = acc_stb && bus_io && bus_wr;
	assign is_plus3  = (model_q == model_plus3);

	// Lock bit freezes both paging ports until reset
	assign page_disable = (model_q == model_48) || page_reg[PAGE_LOCK_BIT];

	// ==================================================
	// Address decode
	// ==================================================
	assign sel_7ffd = !bus_addr[15] && !bus_addr[1]
		&& (bus_addr[14] || !is_plus3) && !page_disable;

	// +3 only
	assign sel_1ffd = bus_addr[12] && (bus_addr[15:13] == 3'b000) && !bus_addr[1]
		&& is_plus3 && !page_disable;

	assign sel_ula = !bus_addr[0];

	// Model is only taken while reset is held
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q <= model;
		end
	end

	// ==================================================
	// Paging registers
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_reg    <= '0;
			page_reg_p3 <= '0;
		end else if (io_wr_stb) begin
			if (sel_7ffd) begin
				page_reg <= bus_wdata;
			end
			if (sel_1ffd) begin
				page_reg_p3 <= bus_wdata;
			end
		end
	end

	// ULA port, border and beeper lines
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border  <= 3'd0;
			ear_out <= 1'b0;
			mic_out <= 1'b0;
		end else if (io_wr_stb && sel_ula) begin
			border  <= bus_wdata[2:0];
			mic_out <= bus_wdata[3];
			ear_out <= bus_wdata[4];
		end
	end

	// EAR input shows in bit 6, the rest float high
	always_comb begin
		ula_rdata    = IO_IDLE_DATA;
		ula_rdata[6] = ear_in;
	end

	assign io_rdata = sel_ula ? ula_rdata : IO_IDLE_DATA;

endmodule

/* source/mem_map.sv */
/*
 Memory map: CPU address to physical store address, with ROM write refusal
*/
`timescale 1ns/1ps

module mem_map (
	input  zx_pkg::cpu_addr_t  bus_addr,
	input  zx_pkg::data_t      page_reg,
	input  zx_pkg::data_t      page_reg_p3,
	input  zx_pkg::model_t     model_q,
	output zx_pkg::phys_addr_t phys_addr,
	output logic               mem_we_ok,
	output logic               scr_page
);
	import zx_pkg::*;

	logic [1:0]               window;
	logic [PAGE_OFFSET_W-1:0] offset;
	logic                     special;
	logic                     is_rom;
	rom_page_t                rom_page;
	bank_t                    bank_normal;
	bank_t                    bank_special;
	bank_t                    bank;

	assign window  = bus_addr[15:14];
	assign offset  = bus_addr[PAGE_OFFSET_W-1:0];
	assign special = (model_q == model_plus3) && page_reg_p3[P3_SPECIAL_BIT];
	assign is_rom  = !special && (window == 2'd0);

	always_comb begin
		case (model_q)
			model_48:    rom_page = 2'd1;
			model_plus3: rom_page = {page_reg_p3[2], page_reg[ROM_SEL_BIT]};
			default:     rom_page = {1'b0, page_reg[ROM_SEL_BIT]};
		endcase
	end

	// Window 0 falls to the default arm but is ROM in normal mode
	always_comb begin
		case (window)
			2'd1:    bank_normal = BANK_WIN1;
			2'd2:    bank_normal = BANK_WIN2;
			default: bank_normal = (model_q == model_48) ? 3'd0 : page_reg[2:0];
		endcase
	end

	// ==================================================
	// +3 all-RAM table
	// ==================================================
	always_comb begin
		bank_special = {1'b1, window};
		case (page_reg_p3[2:1])
			2'd0: bank_special = {1'b0, window};
			2'd1: bank_special = {1'b1, window};
			2'd2: begin
				if (window == 2'd3) begin
					bank_special = 3'd3;
				end
			end
			2'd3: begin
				if (window == 2'd1) begin
					bank_special = 3'd7;
				end else if (window == 2'd3) begin
					bank_special = 3'd3;
				end
			end
		endcase
	end

	assign bank = special ? bank_special : bank_normal;

	assign phys_addr = is_rom ? ROM_BASE + phys_addr_t'({rom_page, offset})
		: phys_addr_t'({bank, offset});

	assign mem_we_ok = !is_rom;
	assign scr_page  = page_reg[SCR_BIT];

endmodule

/* source/bank_store.sv */
/*
 Byte store for eight RAM banks and four ROM pages, synchronous read
*/
`timescale 1ns/1ps

module bank_store (
	input  logic               clk_sys,
	input  logic               we,
	input  zx_pkg::phys_addr_t addr,
	input  zx_pkg::data_t      wdata,
	output zx_pkg::data_t      rdata
);
	import zx_pkg::*;

	data_t mem [0:STORE_DEPTH-1];

	// ROM pages are never loaded, so they read as zero
	initial begin
		for (int i = 0; i < STORE_DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

/* source/zx_mem_top.sv */
/*
 Memory and port unit top: host sequencer, I/O ports, memory map and store
*/
`timescale 1ns/1ps

module zx_mem_top (
	input  logic              clk_sys,
	input  logic              reset,
	input  zx_pkg::model_t    model,
	input  logic              ear_in,
	input  logic              bus_req,
	input  logic              bus_io,
	input  logic              bus_wr,
	input  zx_pkg::cpu_addr_t bus_addr,
	input  zx_pkg::data_t     bus_wdata,
	output logic              bus_ack,
	output zx_pkg::data_t     bus_rdata,
	output logic [2:0]        border,
	output logic              ear_out,
	output logic              mic_out,
	output logic              scr_page
);
	import zx_pkg::*;

	logic       acc_stb;
	data_t      io_rdata;
	data_t      mem_rdata;
	data_t      page_reg;
	data_t      page_reg_p3;
	model_t     model_q;
	phys_addr_t phys_addr;
	logic       mem_we_ok;
	logic       mem_we;

	// Memory writes only, never into a ROM window
	assign mem_we = acc_stb && !bus_io && bus_wr && mem_we_ok;

	bus_ctrl u_bus_ctrl (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.bus_req   (bus_req),
		.bus_io    (bus_io),
		.bus_wr    (bus_wr),
		.io_rdata  (io_rdata),
		.mem_rdata (mem_rdata),
		.bus_ack   (bus_ack),
		.bus_rdata (bus_rdata),
		.acc_stb   (acc_stb)
	);

	io_ports u_io_ports (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.model       (model),
		.acc_stb     (acc_stb),
		.bus_io      (bus_io),
		.bus_wr      (bus_wr),
		.bus_addr    (bus_addr),
		.bus_wdata   (bus_wdata),
		.ear_in      (ear_in),
		.io_rdata    (io_rdata),
		.page_reg    (page_reg),
		.page_reg_p3 (page_reg_p3),
		.model_q     (model_q),
		.border      (border),
		.ear_out     (ear_out),
		.mic_out     (mic_out)
	);

	mem_map u_mem_map (
		.bus_addr    (bus_addr),
		.page_reg    (page_reg),
		.page_reg_p3 (page_reg_p3),
		.model_q     (model_q),
		.phys_addr   (phys_addr),
		.mem_we_ok   (mem_we_ok),
		.scr_page    (scr_page)
	);

	bank_store u_bank_store (
		.clk_sys (clk_sys),
		.we      (mem_we),
		.addr    (phys_addr),
		.wdata   (bus_wdata),
		.rdata   (mem_rdata)
	);

endmodule

/* sim/tb_clock.sv */
/*
 Testbench clock and reset: 4 ns clk_sys, reset held for the first 4 cycles
 and again whenever the testbench requests it
*/
`timescale 1ns/1ps

module tb_clock (
	input  logic reset_req,
	output logic clk_sys,
	output logic reset
);

	localparam real HALF_PERIOD  = 2.0;
	localparam int  RESET_CYCLES = 4;

	logic req_q;

	initial begin
		clk_sys = 1'b0;
		forever #(HALF_PERIOD) clk_sys = ~clk_sys;
	end

	// Request taken on the rising edge, reset moves on the falling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		forever begin
			req_q = reset_req;
			@(negedge clk_sys);
			reset = req_q;
			@(posedge clk_sys);
		end
	end

endmodule

/* sim/zx_bus_assert.sv */
/*
 Handshake assertions for the host bus sequencer, bound into bus_ctrl
*/
`timescale 1ns/1ps

module zx_bus_assert (
	input logic          clk_sys,
	input logic          reset,
	input logic          bus_req,
	input logic          bus_ack,
	input logic          acc_stb,
	input zx_pkg::data_t bus_rdata
);

	// Ack only ever answers a request
	ack_needs_req: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(bus_ack) |-> $past(bus_req))
		else $error("bus_ack rose while bus_req was low");

	// Back-pressure holds the ack
	ack_held: assert property (@(posedge clk_sys) disable iff (reset)
		bus_ack && bus_req |=> bus_ack)
		else $error("bus_ack dropped while bus_req was still high");

	// One strobe per request, none while the ack is out
	single_strobe: assert property (@(posedge clk_sys) disable iff (reset)
		(acc_stb || bus_ack) |=> !acc_stb)
		else $error("acc_stb repeated within one handshake");

	rdata_stable: assert property (@(posedge clk_sys) disable iff (reset)
		bus_ack && $past(bus_ack) |-> $stable(bus_rdata))
		else $error("bus_rdata changed while bus_ack was high");

endmodule

bind bus_ctrl zx_bus_assert u_bus_assert (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.bus_req   (bus_req),
	.bus_ack   (bus_ack),
	.acc_stb   (acc_stb),
	.bus_rdata (bus_rdata)
);

/* sim/tb_top.sv */
/*
 Testbench for the memory and port unit: directed tests over the four-phase
 host bus, checked against a reference model of the paging rules
*/
`timescale 1ns/1ps

module tb_top;
	import zx_pkg::*;

	// About 450 accesses of 7 cycles each, with a wide margin
	localparam int TIMEOUT_CYCLES  = 20000;
	localparam int ACK_LATENCY     = 2;
	localparam int RELEASE_LATENCY = 1;

	logic       clk_sys;
	logic       reset;
	logic       reset_req;
	model_t     model;
	logic       ear_in;
	logic       bus_req;
	logic       bus_io;
	logic       bus_wr;
	cpu_addr_t  bus_addr;
	data_t      bus_wdata;
	logic       bus_ack;
	data_t      bus_rdata;
	logic [2:0] border;
	logic       ear_out;
	logic       mic_out;
	logic       scr_page;

	int seed;
	int errors;
	int checks;
	int cycle_count = 0;

	// ==================================================
	// Reference model state
	// ==================================================
	model_t     ref_model;
	data_t      ref_page;
	data_t      ref_p3;
	logic [2:0] ref_border;
	logic       ref_ear;
	logic       ref_mic;
	data_t      ref_ram [0:131071];

	// +3 all-RAM banks, one row per configuration
	int special_banks [0:3][0:3] = '{'{0, 1, 2, 3}, '{4, 5, 6, 7}, '{4, 5, 6, 3}, '{4, 7, 6, 3}};

	tb_clock u_clock (
		.reset_req (reset_req),
		.clk_sys   (clk_sys),
		.reset     (reset)
	);

	zx_mem_top dut (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.model     (model),
		.ear_in    (ear_in),
		.bus_req   (bus_req),
		.bus_io    (bus_io),
		.bus_wr    (bus_wr),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_ack   (bus_ack),
		.bus_rdata (bus_rdata),
		.border    (border),
		.ear_out   (ear_out),
		.mic_out   (mic_out),
		.scr_page  (scr_page)
	);

	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	task automatic check_equal(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("Fail %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// RAM index of a CPU address, -1 for ROM
	function automatic int ref_location(cpu_addr_t addr);
		int win;
		int bank;
		win = int'(addr[15:14]);
		if (ref_model == model_plus3 && ref_p3[0]) begin
			bank = special_banks[ref_p3[2:1]][win];
		end else begin
			case (win)
				0: return -1;
				1: bank = 5;
				2: bank = 2;
				default: bank = (ref_model == model_48) ? 0 : int'(ref_page[2:0]);
			endcase
		end
		return bank * 16384 + int'(addr[13:0]);
	endfunction

	function automatic void ref_io_write(cpu_addr_t addr, data_t data);
		logic locked;
		locked = (ref_model == model_48) || ref_page[5];
		if (!addr[15] && !addr[1] && !locked && (ref_model != model_plus3 || addr[14])) begin
			ref_page = data;
		end else if (ref_model == model_plus3 && !locked && addr[15:12] == 4'b0001
			&& !addr[1]) begin
			ref_p3 = data;
		end
		if (!addr[0]) begin
			ref_border = data[2:0];
			ref_mic    = data[3];
			ref_ear    = data[4];
		end
	endfunction

	function automatic data_t ref_read(logic io, cpu_addr_t addr);
		int loc;
		if (io) begin
			return addr[0] ? 8'hFF : {1'b1, ear_in, 6'h3F};
		end
		loc = ref_location(addr);
		return (loc < 0) ? 8'h00 : ref_ram[loc[16:0]];
	endfunction

	function automatic void clear_reference(model_t m);
		ref_model  = m;
		ref_page   = '0;
		ref_p3     = '0;
		ref_border = '0;
		ref_ear    = 1'b0;
		ref_mic    = 1'b0;
	endfunction

	function automatic cpu_addr_t probe_addr(cpu_addr_t base, int bank, int idx);
		return base | cpu_addr_t'((bank * 'h0811 + idx * 'h1357) & 'h3FFF);
	endfunction

	// ==================================================
	// Four-phase host access
	// ==================================================
	task automatic bus_cycle(input logic io, input logic wr, input cpu_addr_t addr,
		input data_t wdata, output data_t rdata);
		int ack_wait;
		int rel_wait;
		@(negedge clk_sys);
		bus_io    = io;
		bus_wr    = wr;
		bus_addr  = addr;
		bus_wdata = wdata;
		bus_req   = 1'b1;
		ack_wait  = 0;
		do begin
			@(negedge clk_sys);
			ack_wait++;
		end while (!bus_ack);
		// Counted from the edge that first samples bus_req
		check_equal("ack latency", ACK_LATENCY, ack_wait - 1);
		rdata = bus_rdata;
		// Back-pressure for one cycle, ack and data must hold
		@(negedge clk_sys);
		check_equal("ack held", 1, int'(bus_ack));
		check_equal("rdata held", int'(rdata), int'(bus_rdata));
		bus_req  = 1'b0;
		rel_wait = 0;
		do begin
			@(negedge clk_sys);
			rel_wait++;
		end while (bus_ack);
		check_equal("ack release", RELEASE_LATENCY, rel_wait - 1);
	endtask

	task automatic bus_write(input logic io, input cpu_addr_t addr, input data_t data);
		data_t unused;
		int    loc;
		bus_cycle(io, 1'b1, addr, data, unused);
		if (io) begin
			ref_io_write(addr, data);
		end else begin
			loc = ref_location(addr);
			if (loc >= 0) begin
				ref_ram[loc[16:0]] = data;
			end
		end
	endtask

	task automatic bus_read(input string name, input logic io, input cpu_addr_t addr);
		data_t expected;
		data_t actual;
		expected = ref_read(io, addr);
		bus_cycle(io, 1'b0, addr, 8'h00, actual);
		check_equal(name, int'(expected), int'(actual));
	endtask

	task automatic apply_reset(input model_t m);
		@(negedge clk_sys);
		model     = m;
		reset_req = 1'b1;
		repeat (6) @(negedge clk_sys);
		reset_req = 1'b0;
		do begin
			@(posedge clk_sys);
		end while (reset);
		@(negedge clk_sys);
		clear_reference(m);
		check_equal("reset outputs", 0, int'({bus_ack, border, ear_out, mic_out}));
	endtask

	// ==================================================
	// Directed tests
	// ==================================================
	task automatic default_map();
		bus_write(1'b0, 16'hC010, data_t'($random(seed)));
		bus_read("default bank 0 at c000", 1'b0, 16'hC010);
		bus_write(1'b1, 16'h7FFD, 8'h05);
		bus_write(1'b0, 16'hC123, data_t'($random(seed)));
		bus_read("default bank 5 at 4000", 1'b0, 16'h4123);
		bus_write(1'b0, 16'h8456, data_t'($random(seed)));
		bus_write(1'b1, 16'h7FFD, 8'h02);
		bus_read("default bank 2 at c000", 1'b0, 16'hC456);
		bus_write(1'b1, 16'h7FFD, 8'h08);
		check_equal("screen page", 1, int'(scr_page));
		bus_read("default bank 0 again", 1'b0, 16'hC010);
	endtask

	task automatic bank_switching();
		for (int b = 0; b < 8; b++) begin
			bus_write(1'b1, 16'h7FFD, data_t'(b));
			for (int i = 0; i < 4; i++) begin
				bus_write(1'b0, probe_addr(16'hC000, b, i), data_t'($random(seed)));
			end
		end
		for (int sel = 0; sel < 8; sel++) begin
			bus_write(1'b1, 16'h7FFD, data_t'(sel));
			for (int b = 0; b < 8; b++) begin
				for (int i = 0; i < 4; i++) begin
					bus_read("bank switching", 1'b0, probe_addr(16'hC000, b, i));
				end
			end
		end
		// Lock with bank 3 in place, later writes must not move it
		bus_write(1'b1, 16'h7FFD, 8'h23);
		bus_write(1'b1, 16'h7FFD, 8'h01);
		for (int i = 0; i < 4; i++) begin
			bus_read("locked paging", 1'b0, probe_addr(16'hC000, 3, i));
		end
	endtask

	task automatic mode_48k();
		apply_reset(model_48);
		bus_write(1'b1, 16'h7FFD, 8'h07);
		for (int i = 0; i < 4; i++) begin
			bus_write(1'b0, probe_addr(16'hC000, 7, i), data_t'($random(seed)));
		end
		for (int i = 0; i < 4; i++) begin
			bus_read("48k c000 bank 0", 1'b0, probe_addr(16'hC000, 7, i));
			bus_read("48k c000 bank 0", 1'b0, probe_addr(16'hC000, 0, i));
		end
		bus_write(1'b1, 16'h1FFD, 8'h01);
		bus_write(1'b0, 16'h0040, data_t'($random(seed)));
		bus_read("48k 1ffd ignored", 1'b0, 16'h0040);
	endtask

	task automatic plus3_special();
		cpu_addr_t addr;
		apply_reset(model_plus3);
		for (int cfg = 0; cfg < 4; cfg++) begin
			bus_write(1'b1, 16'h1FFD, data_t'(cfg * 2 + 1));
			for (int w = 0; w < 4; w++) begin
				addr = probe_addr(cpu_addr_t'(w << 14), cfg, w);
				bus_write(1'b0, addr, data_t'($random(seed)));
				bus_read("plus3 special window", 1'b0, addr);
			end
			// Back to normal paging, look for each byte through C000
			bus_write(1'b1, 16'h1FFD, 8'h00);
			for (int w = 0; w < 4; w++) begin
				bus_write(1'b1, 16'h7FFD, data_t'(special_banks[cfg][w]));
				bus_read("plus3 table bank", 1'b0, probe_addr(16'hC000, cfg, w));
			end
		end
	endtask

	task automatic rom_protection();
		for (int pg = 0; pg < 4; pg++) begin
			bus_write(1'b1, 16'h1FFD, data_t'((pg >> 1) << 2));
			bus_write(1'b1, 16'h7FFD, data_t'((pg & 1) << 4));
			for (int i = 0; i < 2; i++) begin
				bus_write(1'b0, probe_addr(16'h0000, pg, i), data_t'($random(seed)));
				bus_read("plus3 rom protected", 1'b0, probe_addr(16'h0000, pg, i));
			end
		end
		apply_reset(model_128);
		for (int pg = 0; pg < 2; pg++) begin
			bus_write(1'b1, 16'h7FFD, data_t'(pg << 4));
			bus_write(1'b0, probe_addr(16'h0000, pg, 0), data_t'($random(seed)));
			bus_read("128k rom protected", 1'b0, probe_addr(16'h0000, pg, 0));
		end
		// No all-RAM mode outside +3
		bus_write(1'b1, 16'h1FFD, 8'h01);
		bus_write(1'b0, 16'h0080, data_t'($random(seed)));
		bus_read("128k 1ffd ignored", 1'b0, 16'h0080);
	endtask

	task automatic ula_port();
		data_t value;
		for (int i = 0; i < 4; i++) begin
			value = data_t'($random(seed));
			bus_write(1'b1, 16'h00FE, value);
			check_equal("ula border", int'(ref_border), int'(border));
			check_equal("ula mic out", int'(ref_mic), int'(mic_out));
			check_equal("ula ear out", int'(ref_ear), int'(ear_out));
		end
		@(negedge clk_sys);
		ear_in = 1'b1;
		bus_read("ula ear in high", 1'b1, 16'h00FE);
		@(negedge clk_sys);
		ear_in = 1'b0;
		bus_read("ula ear in low", 1'b1, 16'h00FE);
		bus_read("unclaimed port", 1'b1, 16'h00FF);
		bus_read("unclaimed port", 1'b1, 16'h7FFD);
	endtask

	initial begin
		seed      = 32'h12917e6a;
		errors    = 0;
		checks    = 0;
		reset_req = 1'b0;
		model     = model_128;
		ear_in    = 1'b0;
		bus_req   = 1'b0;
		bus_io    = 1'b0;
		bus_wr    = 1'b0;
		bus_addr  = '0;
		bus_wdata = '0;
		clear_reference(model_128);
		for (int i = 0; i < 131072; i++) begin
			ref_ram[i] = '0;
		end
		do begin
			@(posedge clk_sys);
		end while (reset);
		@(negedge clk_sys);
		check_equal("reset outputs", 0, int'({bus_ack, border, ear_out, mic_out}));

		default_map();
		bank_switching();
		mode_48k();
		plus3_special();
		rom_protection();
		ula_port();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* compile.f */
source/zx_pkg.sv
source/bus_ctrl.sv
source/io_ports.sv
source/mem_map.sv
source/bank_store.sv
source/zx_mem_top.sv
sim/tb_clock.sv
sim/zx_bus_assert.sv
sim/tb_top.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv --timescale 1ns/1ps \
		--top-module tb_top -Mdir obj_dir -f compile.f

run: compile
	@out="$$(./obj_dir/Vtb_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
